// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_top
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk_i,
    input  logic              reset,
    input  rv_pkg::word_t     if_pc_i,
    input  rv_pkg::word_t     if_instr_i,
    output logic              stall_o,          // load-use hazard
    output logic              branch_taken_o,
    output rv_pkg::word_t     branch_target_o,
    input  rv_pkg::reg_addr_t dbg_addr_i,
    output rv_pkg::word_t     dbg_data_o,
    id_ex_if.decode           id_ex,
    wb_if.reader              wb
);

    rv_pkg::opcode_e   opcode;
    logic [2:0]        funct3;
    rv_pkg::reg_addr_t rs1, rs2, rd;
    rv_pkg::word_t     rs1_data, rs2_data;
    rv_pkg::word_t     imm_i, imm_s, imm_b;
    rv_pkg::alu_op_e   alu_op;
    logic              alu_src, reg_write, mem_read, mem_write, mem_to_reg;
    logic              is_beq;

    assign opcode = rv_pkg::opcode_e'(if_instr_i[6:0]);
    assign funct3 = if_instr_i[14:12];
    assign rs1    = if_instr_i[19:15];
    assign rs2    = if_instr_i[24:20];
    assign rd     = if_instr_i[11:7];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b = {{20{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8]};   // offset in halfwords

    register_file u_regs (
        .clk_i      (clk_i),
        .reset      (reset),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb         (wb),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

    // main and alu-control decode in one place
    always_comb begin
        alu_op     = rv_pkg::ALU_ADD;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        is_beq     = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                reg_write = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: alu_op = if_instr_i[30] ? rv_pkg::ALU_SUB
                                                                : rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLT:     alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::F3_OR:      alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND:     alu_op = rv_pkg::ALU_AND;
                    default:            alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin   // addi only
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin     // address = rs1 + imm_i
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            rv_pkg::OPC_STORE: begin    // address = rs1 + imm_s
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::OPC_BRANCH: is_beq = (funct3 == rv_pkg::F3_BEQ);
            default: ;                  // unknown word acts as a nop
        endcase
    end

    // load in ID/EX feeding the instruction sitting in decode
    assign stall_o = id_ex.mem_read && (id_ex.rd != '0) &&
                     ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    // comparator operands come straight from the regfile
    assign branch_taken_o  = is_beq && (rs1_data == rs2_data) && !stall_o;
    assign branch_target_o = if_pc_i + (imm_b << 1);

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex.reg_write  <= 1'b0;
            id_ex.mem_read   <= 1'b0;
            id_ex.mem_write  <= 1'b0;
            id_ex.mem_to_reg <= 1'b0;
        end else begin   // stall turns the slot into a bubble
            id_ex.reg_write  <= reg_write && !stall_o;
            id_ex.mem_read   <= mem_read && !stall_o;
            id_ex.mem_write  <= mem_write && !stall_o;
            id_ex.mem_to_reg <= mem_to_reg && !stall_o;
        end
    end

    always_ff @(posedge clk_i) begin
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= mem_write ? imm_s : imm_i;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= rd;
        id_ex.alu_op   <= alu_op;
        id_ex.alu_src  <= alu_src;
    end

    // an unrecognised opcode must reach execute as a bubble
    a_unknown_is_bubble: assert property (@(posedge clk_i) disable iff (reset)
        !(if_instr_i[6:0] inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD,
                                  rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH})
        |=> !(id_ex.reg_write || id_ex.mem_read || id_ex.mem_write));

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic      clk_i,
    input  logic      reset,
    id_ex_if.execute  id_ex,
    ex_mem_if.execute ex_mem,
    wb_if.reader      wb
);

    rv_pkg::fwd_sel_e fwd_a, fwd_b;
    rv_pkg::word_t    op_a, rs2_val, op_b;
    rv_pkg::word_t    alu_result;

    // younger producer in EX/MEM wins over writeback
    function automatic rv_pkg::fwd_sel_e pick_fwd(input rv_pkg::reg_addr_t rs);
        if (ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == rs)) begin
            return rv_pkg::FWD_EX_MEM;
        end
        if (wb.reg_write && (wb.rd != '0) && (wb.rd == rs)) begin
            return rv_pkg::FWD_MEM_WB;
        end
        return rv_pkg::FWD_REG;
    endfunction

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t    reg_val);
        case (sel)
            rv_pkg::FWD_EX_MEM: return ex_mem.alu_result;
            rv_pkg::FWD_MEM_WB: return wb.data;
            default:            return reg_val;
        endcase
    endfunction

    always_comb fwd_a   = pick_fwd(id_ex.rs1);
    always_comb fwd_b   = pick_fwd(id_ex.rs2);
    always_comb op_a    = fwd_mux(fwd_a, id_ex.rs1_data);
    always_comb rs2_val = fwd_mux(fwd_b, id_ex.rs2_data);   // also the store data
    assign op_b    = id_ex.alu_src ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::ALU_SUB: alu_result = op_a - op_b;
            rv_pkg::ALU_AND: alu_result = op_a & op_b;
            rv_pkg::ALU_OR:  alu_result = op_a | op_b;
            rv_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:         alu_result = op_a + op_b;   // add, addi, lw/sw address
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
        end else begin
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_val;
        ex_mem.rd         <= id_ex.rd;
    end

    // decode never issues a load and a store in one slot
    a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (reset)
        !(id_ex.mem_read && id_ex.mem_write));

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
    input  logic          clk_i,
    input  logic          reset,
    input  logic          stall_i,          // load-use hold from decode
    input  logic          branch_taken_i,   // beq resolved taken in decode
    input  rv_pkg::word_t branch_target_i,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_data_i,
    output rv_pkg::word_t if_pc_o,          // IF/ID pc
    output rv_pkg::word_t if_instr_o        // IF/ID instruction
);

    rv_pkg::word_t pc_q;
    rv_pkg::word_t pc_next;

    assign imem_addr_o = pc_q;   // imem reads in the same cycle

    always_comb begin
        if (stall_i) begin
            pc_next = pc_q;                    // refetch same word
        end else if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else begin
            pc_next = pc_q + rv_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q       <= rv_pkg::RESET_PC;
            if_pc_o    <= rv_pkg::RESET_PC;
            if_instr_o <= rv_pkg::NOP_INSTR;   // bubble in IF/ID
        end else begin
            pc_q <= pc_next;
            if (!stall_i) begin
                if_pc_o    <= pc_q;
                // wrong-path word behind a taken beq is squashed
                if_instr_o <= branch_taken_i ? rv_pkg::NOP_INSTR : imem_data_i;
            end
        end
    end

    // decode must suppress the branch while it holds the pipe
    a_no_branch_in_stall: assert property (@(posedge clk_i) disable iff (reset)
        !(branch_taken_i && stall_i));

endmodule

// ==== source/mem_wb_stage.sv ====
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic                           clk_i,
    input  logic                           reset,
    ex_mem_if.memory                       ex_mem,
    output logic [rv_pkg::DMEM_ADDR_W-1:0] dmem_addr_o,   // word address
    output rv_pkg::word_t                  dmem_wdata_o,
    output logic                           dmem_we_o,     // one cycle per sw
    input  rv_pkg::word_t                  dmem_rdata_i,
    wb_if.writer                           wb
);

    rv_pkg::word_t     alu_q, rdata_q;
    rv_pkg::reg_addr_t rd_q;
    logic              reg_write_q, mem_to_reg_q;

    // drop the byte offset for word accesses
    assign dmem_addr_o  = ex_mem.alu_result[rv_pkg::DMEM_ADDR_W+1:2];
    assign dmem_wdata_o = ex_mem.store_data;
    assign dmem_we_o    = ex_mem.mem_write;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end else begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_q <= ex_mem.alu_result;
        rd_q  <= ex_mem.rd;
        if (ex_mem.mem_read) begin
            rdata_q <= dmem_rdata_i;   // capture only on lw
        end
    end

    assign wb.reg_write = reg_write_q;
    assign wb.rd        = rd_q;
    assign wb.data      = mem_to_reg_q ? rdata_q : alu_q;

endmodule

// ==== source/pipe_intf.sv ====
`timescale 1ns/1ns

interface id_ex_if;
    rv_pkg::word_t     rs1_data;    // register reads from decode
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     imm;         // I or S immediate
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::alu_op_e   alu_op;
    logic              alu_src;     // 1 selects imm as operand b
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              mem_to_reg;

    modport decode (output rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op,
                    alu_src, reg_write, mem_read, mem_write, mem_to_reg);
    modport execute (input rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op,
                     alu_src, reg_write, mem_read, mem_write, mem_to_reg);
endinterface

interface ex_mem_if;
    rv_pkg::word_t     alu_result;  // also the byte address for lw/sw
    rv_pkg::word_t     store_data;  // forwarded rs2
    rv_pkg::reg_addr_t rd;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              mem_to_reg;

    modport execute (output alu_result, store_data, rd, reg_write, mem_read,
                     mem_write, mem_to_reg);
    modport memory (input alu_result, store_data, rd, reg_write, mem_read,
                    mem_write, mem_to_reg);
endinterface

interface wb_if;
    logic              reg_write;   // write strobe to the register file
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;        // load data or alu result

    modport writer (output reg_write, rd, data);
    modport reader (input reg_write, rd, data);
endinterface

// ==== source/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic              clk_i,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    wb_if.reader              wb,
    input  rv_pkg::reg_addr_t dbg_addr_i,
    output rv_pkg::word_t     dbg_data_o
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // write-through so decode sees the value retiring this cycle
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (wb.reg_write && (wb.rd != '0) && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];   // regs[0] stays zero
    endfunction

    always_comb rs1_data_o = read_port(rs1_addr_i);
    always_comb rs2_data_o = read_port(rs2_addr_i);
    assign dbg_data_o = regs[dbg_addr_i];   // architectural state only

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && (wb.rd != '0)) begin   // x0 is never written
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// ==== source/rv_pipeline_top.sv ====
`timescale 1ns/1ns

module rv_pipeline_top (
    input  logic                           clk_i,
    input  logic                           reset,
    // instruction memory read combinationally
    output rv_pkg::word_t                  imem_addr_o,
    input  rv_pkg::word_t                  imem_data_i,
    // data memory read combinationally and written on dmem_we_o
    output logic [rv_pkg::DMEM_ADDR_W-1:0] dmem_addr_o,
    output rv_pkg::word_t                  dmem_wdata_o,
    output logic                           dmem_we_o,
    input  rv_pkg::word_t                  dmem_rdata_i,
    // register peek
    input  rv_pkg::reg_addr_t              dbg_addr_i,
    output rv_pkg::word_t                  dbg_data_o
);

    rv_pkg::word_t if_pc, if_instr;       // IF/ID
    rv_pkg::word_t branch_target;
    logic          stall, branch_taken;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_if     wb ();

    fetch_stage u_fetch (
        .clk_i           (clk_i),
        .reset           (reset),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o),
        .imem_data_i     (imem_data_i),
        .if_pc_o         (if_pc),
        .if_instr_o      (if_instr)
    );

    decode_stage u_decode (
        .clk_i           (clk_i),
        .reset           (reset),
        .if_pc_i         (if_pc),
        .if_instr_i      (if_instr),
        .stall_o         (stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .dbg_addr_i      (dbg_addr_i),
        .dbg_data_o      (dbg_data_o),
        .id_ex           (id_ex.decode),
        .wb              (wb.reader)
    );

    execute_stage u_execute (
        .clk_i  (clk_i),
        .reset  (reset),
        .id_ex  (id_ex.execute),
        .ex_mem (ex_mem.execute),
        .wb     (wb.reader)        // forwarding from writeback
    );

    mem_wb_stage u_mem_wb (
        .clk_i        (clk_i),
        .reset        (reset),
        .ex_mem       (ex_mem.memory),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .wb           (wb.writer)
    );

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN        = 32;       // data and address width
    localparam int REG_ADDR_W  = 5;        // register index width
    localparam int NUM_REGS    = 32;       // x0..x31
    localparam int DMEM_ADDR_W = 10;       // word address into data memory

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_STEP   = 32'd4;         // one instruction word
    localparam word_t RESET_PC  = '0;            // first fetch address
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    // funct3 codes of the supported instructions
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,   // add sub and or slt
        OPC_OP_IMM = 7'b0010011,   // addi
        OPC_LOAD   = 7'b0000011,   // lw
        OPC_STORE  = 7'b0100011,   // sw
        OPC_BRANCH = 7'b1100011    // beq
    } opcode_e;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4             // signed compare
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,         // value read in decode
        FWD_EX_MEM = 2'd1,         // alu result one stage ahead
        FWD_MEM_WB = 2'd2          // writeback data two stages ahead
    } fwd_sel_e;

endpackage

// ==== verification/pipe_checker.sv ====
`timescale 1ns/1ns

module pipe_checker (
    input logic                           clk_i,
    input logic                           dmem_we_i,
    input logic [rv_pkg::DMEM_ADDR_W-1:0] dmem_addr_i,
    input rv_pkg::word_t                  dmem_wdata_i,
    input logic                           check_reg_i,    // compare debug port this cycle
    input rv_pkg::reg_addr_t              dbg_addr_i,
    input rv_pkg::word_t                  dbg_data_i
);

    logic [rv_pkg::DMEM_ADDR_W-1:0] exp_addr_q [$];       // stores in program order
    rv_pkg::word_t                  exp_data_q [$];
    rv_pkg::word_t                  exp_regs [rv_pkg::NUM_REGS] = '{default: '0};
    int                             stores_seen     = 0;
    int                             stores_expected = 0;
    int                             passes          = 0;
    int                             failures        = 0;

    task automatic expect_store(input logic [rv_pkg::DMEM_ADDR_W-1:0] addr,
                                input rv_pkg::word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        stores_expected++;
    endtask

    task automatic expect_reg(input rv_pkg::reg_addr_t idx, input rv_pkg::word_t value);
        exp_regs[idx] = value;                            // unlisted regs stay zero
    endtask

    // mid-cycle sampling after the outputs settle
    always @(negedge clk_i) begin : compare
        logic [rv_pkg::DMEM_ADDR_W-1:0] want_addr;
        rv_pkg::word_t                  want_data;
        if (dmem_we_i) begin
            stores_seen++;
            if (exp_addr_q.size() == 0) begin
                $display("store %0d at %0t was not expected: word %0h data %h",
                         stores_seen, $time, dmem_addr_i, dmem_wdata_i);
                failures++;
            end else begin
                want_addr = exp_addr_q.pop_front();
                want_data = exp_data_q.pop_front();
                if (dmem_addr_i === want_addr && dmem_wdata_i === want_data) begin
                    $display("store %0d ok: word %0h data %h",
                             stores_seen, dmem_addr_i, dmem_wdata_i);
                    passes++;
                end else begin
                    $display("Fail at %0t: store %0d wrote word %0h data %h, expected %0h %h",
                             $time, stores_seen, dmem_addr_i, dmem_wdata_i,
                             want_addr, want_data);
                    failures++;
                end
            end
        end
        if (check_reg_i) begin
            if (dbg_data_i === exp_regs[dbg_addr_i]) begin
                $display("reg x%0d ok: %h", dbg_addr_i, dbg_data_i);
                passes++;
            end else begin
                $display("Fail at %0t: reg x%0d reads %h, expected %h",
                         $time, dbg_addr_i, dbg_data_i, exp_regs[dbg_addr_i]);
                failures++;
            end
        end
    end

    task automatic finish_checks(output int fail_total);
        logic [rv_pkg::DMEM_ADDR_W-1:0] lost_addr;
        rv_pkg::word_t                  lost_data;
        while (exp_addr_q.size() > 0) begin               // stores that never showed up
            lost_addr = exp_addr_q.pop_front();
            lost_data = exp_data_q.pop_front();
            $display("store to word %0h with data %h never happened", lost_addr, lost_data);
            failures++;
        end
        $display("%0d checks passed, %0d failed, %0d of %0d expected stores seen",
                 passes, failures, stores_seen, stores_expected);
        fail_total = failures;
    endtask

endmodule

// ==== verification/program_stimulus.txt ====
# I <byte addr> <instr word>   S <word addr> <store data>   R <reg, decimal> <final value>
# all other numbers hex; registers without an R line end at zero
I 00 00700093
I 04 01400113
I 08 002081b3
I 0c 40308233
I 10 0021e2b3
I 14 0042f333
I 18 001223b3
I 1c 0040a433
I 20 00508013
I 24 00302423
I 28 00802503
I 2c 001505b3
I 30 00b12623
I 34 00208463
I 38 00100613
I 3c 00318663
I 40 06300613
I 44 06300693
I 48 00200713
I 4c 00e02023
I 50 00000063
S 002 0000001b
S 008 00000022
S 000 00000002
R 0 00000000
R 1 00000007
R 2 00000014
R 3 0000001b
R 4 ffffffec
R 5 0000001f
R 6 0000000c
R 7 00000001
R 10 0000001b
R 11 00000022
R 12 00000001
R 13 00000000
R 14 00000002

// ==== verification/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;                        // inputs move after the edge
    localparam int RESET_CYCLES = 8;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 1 << rv_pkg::DMEM_ADDR_W;

    logic                           clk;
    logic                           reset;
    rv_pkg::word_t                  imem_addr, imem_data;
    logic [rv_pkg::DMEM_ADDR_W-1:0] dmem_addr;
    rv_pkg::word_t                  dmem_wdata, dmem_rdata;
    logic                           dmem_we;
    rv_pkg::reg_addr_t              dbg_addr;
    rv_pkg::word_t                  dbg_data;
    logic                           check_reg;               // debug port is under comparison
    logic                           loaded;                  // stimulus file read
    int                             prog_len;                // instruction count
    int                             fails;

    rv_pkg::word_t imem [IMEM_WORDS];
    rv_pkg::word_t dmem [DMEM_WORDS];

    assign imem_data  = imem[imem_addr[9:2]];                // combinational reads
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rv_pipeline_top dut_i (
        .clk_i        (clk),
        .reset        (reset),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata),
        .dbg_addr_i   (dbg_addr),
        .dbg_data_o   (dbg_data)
    );

    pipe_checker pipe_chk (
        .clk_i        (clk),
        .dmem_we_i    (dmem_we),
        .dmem_addr_i  (dmem_addr),
        .dmem_wdata_i (dmem_wdata),
        .check_reg_i  (check_reg),
        .dbg_addr_i   (dbg_addr),
        .dbg_data_i   (dbg_data)
    );

    // I lines fill imem while S and R lines go to the checker
    task automatic load_stimulus(output bit ok);
        int            fd;
        int            n;
        logic [7:0]    kind;
        logic [1023:0] line_buf;
        rv_pkg::word_t addr, data;
        bit            done;
        ok   = 1'b1;
        done = 1'b0;
        fd   = $fopen("verification/program_stimulus.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!done) begin
                n = $fscanf(fd, " %c", kind);
                if (n != 1) begin
                    done = 1'b1;                             // end of file
                end else if (kind == "#") begin
                    n = $fgets(line_buf, fd);                // skip rest of comment
                end else if (kind == "I") begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    imem[addr[9:2]] = data;
                    prog_len++;
                    ok = ok && (n == 2);
                end else if (kind == "S") begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    pipe_chk.expect_store(addr[rv_pkg::DMEM_ADDR_W-1:0], data);
                    ok = ok && (n == 2);
                end else if (kind == "R") begin
                    n = $fscanf(fd, "%d %h", addr, data);   // reg number in decimal
                    pipe_chk.expect_reg(addr[4:0], data);
                    ok = ok && (n == 2);
                end else begin
                    ok   = 1'b0;                             // unknown line kind
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : main
        bit ok;
        reset     = 1'b1;
        dbg_addr  = '0;
        check_reg = 1'b0;
        loaded    = 1'b0;
        prog_len  = 0;
        fails     = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {4'h0, i[7:0], 13'd0, 7'b0010011};    // addi x0,x0,i
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {6'h2a, i[9:0], 6'h15, i[9:0]};
        end
        load_stimulus(ok);
        if (!ok) begin
            $display("could not read verification/program_stimulus.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY reset = 1'b0;
            repeat (prog_len * 8 + 50) @(posedge clk);      // program parks in beq self-loop
            for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                dbg_addr  = r[4:0];
                check_reg = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY check_reg = 1'b0;
            pipe_chk.finish_checks(fails);
            if (fails == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // run length plus slack for reset and register readout
    initial begin : watchdog
        wait (loaded);
        repeat (prog_len * 8 + 200) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", prog_len * 8 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/rv_pkg.sv
source/pipe_intf.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv_pipeline_top.sv
verification/pipe_checker.sv
verification/tb_top.sv
